//--- hw/vga_pkg.sv
/*
  Shared constants and types for the 1024x768 arcade video pipeline.
  Timing is the XGA 60 Hz mode on a 65 MHz pixel clock, both syncs active low.
  Game sizes assume the ship, missile and caption stay inside the visible area.
*/
`default_nettype none

package vga_pkg;

  // XGA 1024x768 raster, in pixels and lines
  localparam int H_TOTAL      = 1344;
  localparam int H_ACTIVE     = 1024;
  localparam int H_SYNC_START = 1048;
  localparam int H_SYNC_WIDTH = 136;
  localparam int V_TOTAL      = 806;
  localparam int V_ACTIVE     = 768;
  localparam int V_SYNC_START = 771;
  localparam int V_SYNC_WIDTH = 6;

  typedef logic [10:0] coord_t;
  typedef logic [11:0] rgb_t;
  // Glyph index in the upper 3 bits, glyph row in the lower 4
  typedef logic [6:0]  font_addr_t;
  typedef logic [7:0]  font_row_t;

  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
  } vga_bus_t;

  // Raster value held in every stage while in reset, syncs inactive
  localparam vga_bus_t VGA_BUS_RESET = '{
    hcount: '0, vcount: '0, hsync: 1'b1, vsync: 1'b1, hblnk: 1'b0, vblnk: 1'b0
  };

  localparam rgb_t BG_COLOR     = 12'h124;
  localparam rgb_t BORDER_COLOR = 12'hccc;

  localparam coord_t SHIP_Y      = 11'd700;
  localparam coord_t SHIP_W      = 11'd64;
  localparam coord_t SHIP_H      = 11'd32;
  localparam coord_t SHIP_STEP   = 11'd8;
  localparam coord_t SHIP_X_INIT = 11'd480;
  localparam coord_t SHIP_X_MAX  = coord_t'(H_ACTIVE) - SHIP_W;
  localparam rgb_t   SHIP_COLOR  = 12'h0f0;

  localparam coord_t MISSILE_W       = 11'd4;
  localparam coord_t MISSILE_H       = 11'd16;
  localparam coord_t MISSILE_STEP    = 11'd24;
  localparam coord_t MISSILE_X_OFS   = (SHIP_W - MISSILE_W) / 2;
  localparam coord_t MISSILE_Y_START = SHIP_Y - MISSILE_H;
  localparam rgb_t   MISSILE_COLOR   = 12'hff0;

  // Caption box of one row of 8x16 characters
  localparam coord_t TEXT_X         = 11'd32;
  localparam coord_t TEXT_Y         = 11'd32;
  localparam coord_t TEXT_COLS      = 11'd8;
  localparam coord_t CHAR_W         = 11'd8;
  localparam coord_t CHAR_H         = 11'd16;
  localparam coord_t TEXT_W         = TEXT_COLS * CHAR_W;
  localparam rgb_t   TEXT_BOX_COLOR = 12'h333;
  localparam rgb_t   TEXT_COLOR     = 12'hfa0;

  typedef enum logic {
    IDLE,
    FLYING
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/vga_timing.sv
/*
  Free-running XGA raster generator with registered counters and flags.
  During reset the counters sit at zero and both syncs are inactive (high).
*/
`default_nettype none

module vga_timing
  import vga_pkg::*;
(
  input  logic     pclk,
  input  logic     rst,
  output vga_bus_t vga
);

  coord_t h_next;
  coord_t v_next;

  // Next raster position, with line wrap and frame wrap
  always_comb begin
    if (vga.hcount == coord_t'(H_TOTAL - 1)) begin
      h_next = '0;
      if (vga.vcount == coord_t'(V_TOTAL - 1)) begin
        v_next = '0;
      end else begin
        v_next = vga.vcount + 11'd1;
      end
    end else begin
      h_next = vga.hcount + 11'd1;
      v_next = vga.vcount;
    end
  end

  // Flags come from the next counter values so they line up with the counters
  always_ff @(posedge pclk) begin
    if (rst) begin
      vga <= VGA_BUS_RESET;
    end else begin
      vga.hcount <= h_next;
      vga.vcount <= v_next;
      vga.hsync  <= !((h_next >= H_SYNC_START) &&
                      (h_next < H_SYNC_START + H_SYNC_WIDTH));
      vga.vsync  <= !((v_next >= V_SYNC_START) &&
                      (v_next < V_SYNC_START + V_SYNC_WIDTH));
      vga.hblnk  <= (h_next >= H_ACTIVE);
      vga.vblnk  <= (v_next >= V_ACTIVE);
    end
  end

endmodule

`default_nettype wire

//--- hw/draw_background.sv
/*
  Background painter with one cycle of latency.
  Blanking pixels are black, the outermost visible ring is the border colour.
*/
`default_nettype none

module draw_background
  import vga_pkg::*;
(
  input  logic     pclk,
  input  logic     rst,
  input  vga_bus_t vga_in,
  output vga_bus_t vga_out,
  output rgb_t     rgb_out
);

  logic blank;
  logic on_border;

  assign blank = vga_in.hblnk || vga_in.vblnk;

  assign on_border = (vga_in.hcount == '0) ||
                     (vga_in.hcount == coord_t'(H_ACTIVE - 1)) ||
                     (vga_in.vcount == '0) ||
                     (vga_in.vcount == coord_t'(V_ACTIVE - 1));

  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out <= VGA_BUS_RESET;
      rgb_out <= '0;
    end else begin
      vga_out <= vga_in;
      if (blank) begin
        rgb_out <= '0;
      end else if (on_border) begin
        rgb_out <= BORDER_COLOR;
      end else begin
        rgb_out <= BG_COLOR;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/ship_control.sv
/*
  Game state for the ship and its missile, updated once per frame.
  Buttons are sampled only in the frame start cycle and must already be
  synchronous to pclk. Only one missile can be in flight at a time.
*/
`default_nettype none

module ship_control
  import vga_pkg::*;
(
  input  logic     pclk,
  input  logic     rst,
  input  vga_bus_t vga_in,
  input  logic     left,
  input  logic     right,
  input  logic     missile_button,
  output coord_t   ship_x,
  output coord_t   missile_x,
  output coord_t   missile_y,
  output logic     missile_active
);

  ctrl_state_t state;
  logic        frame_start;
  logic        launch;
  logic        climb;
  coord_t      ship_x_next;

  // First pixel of the frame, seen one cycle before the drawing stages see it
  assign frame_start = (vga_in.hcount == '0) && (vga_in.vcount == '0);

  assign launch = frame_start && (state == IDLE) && missile_button;
  assign climb  = frame_start && (state == FLYING) && (missile_y >= MISSILE_STEP);

  // Ship move, clamped to the visible width
  always_comb begin
    ship_x_next = ship_x;
    if (right && !left) begin
      if (ship_x > SHIP_X_MAX - SHIP_STEP) begin
        ship_x_next = SHIP_X_MAX;
      end else begin
        ship_x_next = ship_x + SHIP_STEP;
      end
    end else if (left && !right) begin
      if (ship_x < SHIP_STEP) begin
        ship_x_next = '0;
      end else begin
        ship_x_next = ship_x - SHIP_STEP;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      state  <= IDLE;
      ship_x <= SHIP_X_INIT;
    end else if (frame_start) begin
      ship_x <= ship_x_next;
      case (state)
        IDLE: if (missile_button) state <= FLYING;
        // Leaves the screen once another climb would pass line 0
        FLYING: if (missile_y < MISSILE_STEP) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Missile launches from the nose of the ship as drawn in this frame
  always_ff @(posedge pclk) begin
    if (launch) begin
      missile_x <= ship_x_next + MISSILE_X_OFS;
      missile_y <= MISSILE_Y_START;
    end else if (climb) begin
      missile_y <= missile_y - MISSILE_STEP;
    end
  end

  assign missile_active = (state == FLYING);

endmodule

`default_nettype wire

//--- hw/draw_ship.sv
/*
  Ship and missile overlay with one cycle of latency.
  The missile is drawn over the ship where the two overlap.
  Blanking pixels keep the incoming colour.
*/
`default_nettype none

module draw_ship
  import vga_pkg::*;
(
  input  logic     pclk,
  input  logic     rst,
  input  vga_bus_t vga_in,
  input  rgb_t     rgb_in,
  input  coord_t   ship_x,
  input  coord_t   missile_x,
  input  coord_t   missile_y,
  input  logic     missile_active,
  output vga_bus_t vga_out,
  output rgb_t     rgb_out
);

  logic blank;
  logic in_ship;
  logic in_missile;

  assign blank = vga_in.hblnk || vga_in.vblnk;

  assign in_ship = (vga_in.hcount >= ship_x) &&
                   (vga_in.hcount < ship_x + SHIP_W) &&
                   (vga_in.vcount >= SHIP_Y) &&
                   (vga_in.vcount < SHIP_Y + SHIP_H);

  // Position is only meaningful while the missile flies
  assign in_missile = missile_active &&
                      (vga_in.hcount >= missile_x) &&
                      (vga_in.hcount < missile_x + MISSILE_W) &&
                      (vga_in.vcount >= missile_y) &&
                      (vga_in.vcount < missile_y + MISSILE_H);

  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out <= VGA_BUS_RESET;
      rgb_out <= '0;
    end else begin
      vga_out <= vga_in;
      if (blank) begin
        rgb_out <= rgb_in;
      end else if (in_missile) begin
        rgb_out <= MISSILE_COLOR;
      end else if (in_ship) begin
        rgb_out <= SHIP_COLOR;
      end else begin
        rgb_out <= rgb_in;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/font_rom.sv
/*
  Synchronous 8x16 font ROM with the eight glyphs of the caption "PLAYER 1".
  Data appears one cycle after the address. Bit 7 is the leftmost pixel.
*/
`default_nettype none

module font_rom
  import vga_pkg::*;
(
  input  logic       pclk,
  input  font_addr_t addr,
  output font_row_t  pixels
);

  // Whole glyph, top row in the most significant byte
  logic [127:0] glyph;

  always_comb begin
    case (addr[6:4])
      3'd0: glyph = 128'h0;
      // P
      3'd1: glyph = 128'h0000fc6666667c60606060f000000000;
      // L
      3'd2: glyph = 128'h0000f06060606060606266fe00000000;
      // A
      3'd3: glyph = 128'h000010386cc6c6fec6c6c6c600000000;
      // Y
      3'd4: glyph = 128'h0000666666663c181818183c00000000;
      // E
      3'd5: glyph = 128'h0000fe6662687868606266fe00000000;
      // R
      3'd6: glyph = 128'h0000fc6666667c6c666666e600000000;
      // Digit one
      default: glyph = 128'h00001838781818181818187e00000000;
    endcase
  end

  always_ff @(posedge pclk) begin
    pixels <= glyph[127 - 8 * int'(addr[3:0]) -: 8];
  end

endmodule

`default_nettype wire

//--- hw/draw_rect_char.sv
/*
  Caption box overlay with two cycles of latency.
  Expects the font ROM to answer one cycle after font_addr.
  The box is one row of 8 characters, so the column fits in bits 5:3 of the x offset.
*/
`default_nettype none

module draw_rect_char
  import vga_pkg::*;
(
  input  logic       pclk,
  input  logic       rst,
  input  vga_bus_t   vga_in,
  input  rgb_t       rgb_in,
  output vga_bus_t   vga_out,
  output rgb_t       rgb_out,
  output font_addr_t font_addr,
  input  font_row_t  font_pixels
);

  coord_t     rel_x;
  coord_t     rel_y;
  logic       in_box;
  logic [2:0] glyph_idx;
  vga_bus_t   vga_d;
  rgb_t       rgb_d;
  logic       in_box_d;
  logic [2:0] bit_col_d;

  assign rel_x = vga_in.hcount - TEXT_X;
  assign rel_y = vga_in.vcount - TEXT_Y;

  assign in_box = (vga_in.hcount >= TEXT_X) && (vga_in.hcount < TEXT_X + TEXT_W) &&
                  (vga_in.vcount >= TEXT_Y) && (vga_in.vcount < TEXT_Y + CHAR_H);

  // One glyph index per column of the caption "PLAYER 1"
  always_comb begin
    case (rel_x[5:3])
      3'd0: glyph_idx = 3'd1;
      3'd1: glyph_idx = 3'd2;
      3'd2: glyph_idx = 3'd3;
      3'd3: glyph_idx = 3'd4;
      3'd4: glyph_idx = 3'd5;
      3'd5: glyph_idx = 3'd6;
      3'd6: glyph_idx = 3'd0;
      default: glyph_idx = 3'd7;
    endcase
  end

  assign font_addr = {glyph_idx, rel_y[3:0]};

  // Stage 1 waits for the ROM
  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_d    <= VGA_BUS_RESET;
      in_box_d <= 1'b0;
    end else begin
      vga_d    <= vga_in;
      in_box_d <= in_box;
    end
  end

  always_ff @(posedge pclk) begin
    rgb_d     <= rgb_in;
    bit_col_d <= rel_x[2:0];
  end

  // Stage 2 picks the glyph bit
  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out <= VGA_BUS_RESET;
      rgb_out <= '0;
    end else begin
      vga_out <= vga_d;
      if (!in_box_d) begin
        rgb_out <= rgb_d;
      end else if (font_pixels[3'd7 - bit_col_d]) begin
        rgb_out <= TEXT_COLOR;
      end else begin
        rgb_out <= TEXT_BOX_COLOR;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/vga_example.sv
/*
  Top level of the arcade screen. pclk is the 65 MHz pixel clock.
  hs, vs and the colour pins lag the raster counters by 4 cycles.
*/
`default_nettype none

module vga_example
  import vga_pkg::*;
(
  input  logic       pclk,
  input  logic       rst,
  input  logic       left,
  input  logic       right,
  input  logic       missile_button,
  output logic       vs,
  output logic       hs,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b
);

  vga_bus_t   vga_tim;
  vga_bus_t   vga_bg;
  vga_bus_t   vga_ship;
  vga_bus_t   vga_txt;
  rgb_t       rgb_bg;
  rgb_t       rgb_ship;
  rgb_t       rgb_txt;
  coord_t     ship_x;
  coord_t     missile_x;
  coord_t     missile_y;
  logic       missile_active;
  font_addr_t font_addr;
  font_row_t  font_pixels;

  vga_timing my_timing (
    .pclk(pclk),
    .rst (rst),
    .vga (vga_tim)
  );

  ship_control my_ship_control (
    .pclk          (pclk),
    .rst           (rst),
    .vga_in        (vga_tim),
    .left          (left),
    .right         (right),
    .missile_button(missile_button),
    .ship_x        (ship_x),
    .missile_x     (missile_x),
    .missile_y     (missile_y),
    .missile_active(missile_active)
  );

  draw_background my_draw_background (
    .pclk   (pclk),
    .rst    (rst),
    .vga_in (vga_tim),
    .vga_out(vga_bg),
    .rgb_out(rgb_bg)
  );

  draw_ship my_draw_ship (
    .pclk          (pclk),
    .rst           (rst),
    .vga_in        (vga_bg),
    .rgb_in        (rgb_bg),
    .ship_x        (ship_x),
    .missile_x     (missile_x),
    .missile_y     (missile_y),
    .missile_active(missile_active),
    .vga_out       (vga_ship),
    .rgb_out       (rgb_ship)
  );

  draw_rect_char my_draw_rect_char (
    .pclk       (pclk),
    .rst        (rst),
    .vga_in     (vga_ship),
    .rgb_in     (rgb_ship),
    .vga_out    (vga_txt),
    .rgb_out    (rgb_txt),
    .font_addr  (font_addr),
    .font_pixels(font_pixels)
  );

  font_rom my_font_rom (
    .pclk  (pclk),
    .addr  (font_addr),
    .pixels(font_pixels)
  );

  // Final stage straight onto the pins
  assign hs = vga_txt.hsync;
  assign vs = vga_txt.vsync;
  assign r  = rgb_txt[11:8];
  assign g  = rgb_txt[7:4];
  assign b  = rgb_txt[3:0];

endmodule

`default_nettype wire

//--- tb/vga_example_assert.sv
/*
  Sync and blanking checks, bound into vga_example.
  The raster position is rebuilt from the pins, so checks start after the
  first hs fall (line checks) and the first vs fall (frame checks).
*/
`default_nettype none

module vga_example_assert
  import vga_pkg::*;
(
  input logic       pclk,
  input logic       rst,
  input logic       hs,
  input logic       vs,
  input logic [3:0] r,
  input logic [3:0] g,
  input logic [3:0] b
);

  timeunit 1ns;
  timeprecision 1ps;

  int   px;
  int   py;
  int   cx;
  int   cy;
  logic hs_q;
  logic vs_q;
  logic h_ok;
  logic v_ok;
  int   assert_failures = 0;

  // Pixel on the pins in this cycle, resynchronised on each sync fall
  always_comb begin
    cx = (px == H_TOTAL - 1) ? 0 : px + 1;
    cy = py;
    if (hs_q && !hs) begin
      cx = H_SYNC_START;
    end
    if (vs_q && !vs) begin
      cy = V_SYNC_START;
    end else if (cx == 0) begin
      cy = (py == V_TOTAL - 1) ? 0 : py + 1;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      px   <= 0;
      py   <= 0;
      hs_q <= 1'b1;
      vs_q <= 1'b1;
      h_ok <= 1'b0;
      v_ok <= 1'b0;
    end else begin
      px   <= cx;
      py   <= cy;
      hs_q <= hs;
      vs_q <= vs;
      if (hs_q && !hs) begin
        h_ok <= 1'b1;
      end
      if (vs_q && !vs) begin
        v_ok <= 1'b1;
      end
    end
  end

  // Each hs fall lands H_TOTAL cycles after the previous one
  hs_period: assert property (@(posedge pclk) disable iff (rst)
    (h_ok && $fell(hs)) |-> (px == H_SYNC_START - 1))
    else begin
      $error("hs falling edges are not H_TOTAL cycles apart");
      assert_failures++;
    end

  hs_width: assert property (@(posedge pclk) disable iff (rst)
    h_ok |-> (!hs == ((cx >= H_SYNC_START) && (cx < H_SYNC_START + H_SYNC_WIDTH))))
    else begin
      $error("hs low outside the sync columns or for the wrong width");
      assert_failures++;
    end

  vs_width: assert property (@(posedge pclk) disable iff (rst)
    v_ok |-> (!vs == ((cy >= V_SYNC_START) && (cy < V_SYNC_START + V_SYNC_WIDTH))))
    else begin
      $error("vs low outside the sync lines or for the wrong number of lines");
      assert_failures++;
    end

  blank_black: assert property (@(posedge pclk) disable iff (rst)
    (v_ok && ((cx >= H_ACTIVE) || (cy >= V_ACTIVE))) |-> ({r, g, b} == 12'h000))
    else begin
      $error("colour pins not black during blanking");
      assert_failures++;
    end

endmodule

`default_nettype wire

//--- tb/vga_example_tb.sv
/*
  Four-frame testbench for the arcade video pipeline.
  Pixel positions come from the hs and vs falls, so pixel checks begin in frame 2.
  Buttons change in vertical blanking and are sampled by the DUT at frame start.
*/
`default_nettype none

module vga_example_tb
  import vga_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = H_TOTAL * V_TOTAL * 9 / 2;
  // Lies past the vs fall of frame 1 where the raster is already rebuilt
  localparam int BUTTON_LINE = V_ACTIVE + 20;
  localparam int LAST_FRAME = 4;

  logic       clk;
  logic       rst;
  logic       left;
  logic       right;
  logic       missile_button;
  logic       hs;
  logic       vs;
  logic [3:0] r;
  logic [3:0] g;
  logic [3:0] b;

  // Pixel currently on the pins
  int   px = 0;
  int   py = 0;
  logic hs_q = 1'b1;
  logic vs_q = 1'b1;
  logic synced = 1'b0;
  int   frame_no = 1;
  logic run_done = 1'b0;

  // Game state model
  int   ship_x_m = int'(SHIP_X_INIT);
  int   mis_x_m = 0;
  int   mis_y_m = 0;
  logic mis_on_m = 1'b0;

  int ship_left [1:4];
  int missile_top [1:4];
  int frame_errors = 0;
  int frame_pixels = 0;
  int error_count = 0;
  int pixel_checks = 0;
  int text_fg = 0;
  int text_bg = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  vga_example DUT (
    .pclk          (clk),
    .rst           (rst),
    .left          (left),
    .right         (right),
    .missile_button(missile_button),
    .vs            (vs),
    .hs            (hs),
    .r             (r),
    .g             (g),
    .b             (b)
  );

  bind vga_example vga_example_assert sync_checks (
    .pclk(pclk),
    .rst (rst),
    .hs  (hs),
    .vs  (vs),
    .r   (r),
    .g   (g),
    .b   (b)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic step_model();
    if (right && !left) begin
      ship_x_m = ship_x_m + int'(SHIP_STEP);
      if (ship_x_m > H_ACTIVE - int'(SHIP_W)) begin
        ship_x_m = H_ACTIVE - int'(SHIP_W);
      end
    end else if (left && !right) begin
      ship_x_m = ship_x_m - int'(SHIP_STEP);
      if (ship_x_m < 0) begin
        ship_x_m = 0;
      end
    end
    if (!mis_on_m) begin
      if (missile_button) begin
        mis_on_m = 1'b1;
        // Missile centred on the ship's centre column
        mis_x_m  = ship_x_m + int'(SHIP_W) / 2 - int'(MISSILE_W) / 2;
        mis_y_m  = int'(SHIP_Y) - int'(MISSILE_H);
      end
    end else if (mis_y_m - int'(MISSILE_STEP) < 0) begin
      mis_on_m = 1'b0;
    end else begin
      mis_y_m = mis_y_m - int'(MISSILE_STEP);
    end
  endtask

  // Colour of a visible pixel outside the caption box
  function automatic rgb_t expected_colour(input int x, input int y);
    if (mis_on_m && (x >= mis_x_m) && (x < mis_x_m + int'(MISSILE_W)) &&
        (y >= mis_y_m) && (y < mis_y_m + int'(MISSILE_H))) begin
      return MISSILE_COLOR;
    end
    if ((x >= ship_x_m) && (x < ship_x_m + int'(SHIP_W)) &&
        (y >= int'(SHIP_Y)) && (y < int'(SHIP_Y) + int'(SHIP_H))) begin
      return SHIP_COLOR;
    end
    if ((x == 0) || (y == 0) || (x == H_ACTIVE - 1) || (y == V_ACTIVE - 1)) begin
      return BORDER_COLOR;
    end
    return BG_COLOR;
  endfunction

  task automatic check_pixel(input int x, input int y, input rgb_t got);
    rgb_t exp;
    logic in_text;
    in_text = (x >= int'(TEXT_X)) && (x < int'(TEXT_X) + int'(TEXT_COLS * CHAR_W)) &&
              (y >= int'(TEXT_Y)) && (y < int'(TEXT_Y) + int'(CHAR_H));
    pixel_checks++;
    frame_pixels++;
    if (in_text) begin
      if (got == TEXT_COLOR) begin
        text_fg++;
      end else if (got == TEXT_BOX_COLOR) begin
        text_bg++;
      end
      assert ((got == TEXT_COLOR) || (got == TEXT_BOX_COLOR)) else begin
        error_count++;
        frame_errors++;
        $display("ERROR t=%0t rgb at (%0d,%0d): got %03h expected %03h or %03h",
                 $time, x, y, got, TEXT_COLOR, TEXT_BOX_COLOR);
      end
    end else begin
      exp = expected_colour(x, y);
      if ((got == MISSILE_COLOR) && (missile_top[frame_no] < 0)) begin
        missile_top[frame_no] = y;
      end
      if ((got == SHIP_COLOR) && (y == int'(SHIP_Y + SHIP_H / 2)) &&
          (ship_left[frame_no] < 0)) begin
        ship_left[frame_no] = x;
      end
      assert (got == exp) else begin
        error_count++;
        frame_errors++;
        $display("ERROR t=%0t rgb at (%0d,%0d): got %03h expected %03h",
                 $time, x, y, got, exp);
      end
    end
  endtask

  task automatic report_test(input string name, input logic ok, input string detail);
    tests_run++;
    if (!ok) begin
      tests_failed++;
    end
    $display("%s: %s (%s)", name, ok ? "ok" : "failed", detail);
  endtask

  // Rebuild the raster from the sync falls and check each visible pixel
  always @(negedge clk) begin
    if (rst) begin
      hs_q   = 1'b1;
      vs_q   = 1'b1;
      synced = 1'b0;
    end else begin
      if (hs_q && !hs) begin
        px = H_SYNC_START;
      end else begin
        px = (px == H_TOTAL - 1) ? 0 : px + 1;
      end
      if (vs_q && !vs) begin
        py     = V_SYNC_START;
        synced = 1'b1;
      end else if (px == 0) begin
        py = (py == V_TOTAL - 1) ? 0 : py + 1;
      end
      hs_q = hs;
      vs_q = vs;
      if (synced && !run_done) begin
        if ((px == 0) && (py == 0)) begin
          frame_no++;
          frame_errors = 0;
          frame_pixels = 0;
          step_model();
        end
        if ((px < H_ACTIVE) && (py < V_ACTIVE) && (frame_no >= 2)) begin
          check_pixel(px, py, {r, g, b});
        end
        if ((px == 0) && (py == V_ACTIVE) && (frame_no >= 2)) begin
          report_test($sformatf("frame %0d raster", frame_no), frame_errors == 0,
                      $sformatf("%0d pixels, %0d errors", frame_pixels, frame_errors));
          if (frame_no == LAST_FRAME) begin
            run_done = 1'b1;
          end
        end
      end
    end
  end

  // Right held for frames 2 and 3 and fire sampled at the start of frame 3
  always @(posedge clk) begin
    if (synced && (px == 0) && (py == BUTTON_LINE)) begin
      case (frame_no)
        1: right <= 1'b1;
        2: missile_button <= 1'b1;
        3: begin
          right          <= 1'b0;
          missile_button <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  initial begin
    rst            = 1'b1;
    left           = 1'b0;
    right          = 1'b0;
    missile_button = 1'b0;
    ship_left      = '{default: -1};
    missile_top    = '{default: -1};
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    while (!run_done && (cycles < TIMEOUT_CYCLES)) begin
      @(posedge clk);
      cycles++;
    end
    if (!run_done) begin
      $display("Timeout after %0d cycles, frame %0d never finished", cycles, LAST_FRAME);
      $display("TB FAILED");
    end else begin
      report_test("ship moved two steps right",
                  ship_left[4] == int'(SHIP_X_INIT) + 2 * int'(SHIP_STEP),
                  $sformatf("left edge %0d in frame 2, %0d in frame 4",
                            ship_left[2], ship_left[4]));
      report_test("missile launched and climbed",
                  (missile_top[2] < 0) &&
                  (missile_top[3] == int'(SHIP_Y) - int'(MISSILE_H)) &&
                  (missile_top[4] == missile_top[3] - int'(MISSILE_STEP)),
                  $sformatf("top row %0d in frame 3, %0d in frame 4",
                            missile_top[3], missile_top[4]));
      report_test("caption colours", (text_fg > 0) && (text_bg > 0),
                  $sformatf("%0d text pixels, %0d box pixels", text_fg, text_bg));
      report_test("sync and blanking assertions", DUT.sync_checks.assert_failures == 0,
                  $sformatf("%0d failures", DUT.sync_checks.assert_failures));
      $display("%0d tests, %0d failed, %0d pixel checks, %0d pixel errors",
               tests_run, tests_failed, pixel_checks, error_count);
      if ((tests_failed == 0) && (error_count == 0)) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hw/vga_pkg.sv
hw/vga_timing.sv
hw/draw_background.sv
hw/ship_control.sv
hw/draw_ship.sv
hw/font_rom.sv
hw/draw_rect_char.sv
hw/vga_example.sv
tb/vga_example_assert.sv
tb/vga_example_tb.sv

//--- Bender.yml
package:
  name: vga_example

sources:
  # RTL, package first
  - target: any(synthesis, simulation)
    files:
      - hw/vga_pkg.sv
      - hw/vga_timing.sv
      - hw/draw_background.sv
      - hw/ship_control.sv
      - hw/draw_ship.sv
      - hw/font_rom.sv
      - hw/draw_rect_char.sv
      - hw/vga_example.sv

  # Testbench and its bound assertions
  - target: simulation
    files:
      - tb/vga_example_assert.sv
      - tb/vga_example_tb.sv
